// File: project.f
common/cache_pkg.sv
logic/tag_store.sv
logic/line_store.sv
l1_cache/cache_ctrl.sv
l1_cache/l1_cache.sv
verification/tb_l1_cache.sv

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_l1_cache -o tb_l1_cache &&
./obj_dir/tb_l1_cache | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verification/tb_l1_cache.sv
// tb_l1_cache: testbench for the L1 data cache, line memory model, shadow reference and checks
`timescale 1ns/1ps

module tb_l1_cache;

    localparam int READY_LIMIT = 40;             // cycles allowed per cpu request
    localparam int RANDOM_OPS  = 300;
    localparam cache_pkg::word_t FILL_PATTERN = 32'h5ac3_96e1;

    logic               sys_clk;
    logic               RST;
    logic               cpu_valid;
    cache_pkg::addr_t   cpu_addr;
    logic               cpu_rw;
    cache_pkg::word_t   cpu_wdata;
    logic               cpu_ready;
    cache_pkg::word_t   cpu_rdata;
    logic               mem_req_valid;
    cache_pkg::addr_t   mem_req_addr;
    logic               mem_req_rw;
    cache_pkg::line_t   mem_req_data;
    logic               mem_resp_ready;
    cache_pkg::line_t   mem_resp_data;

    l1_cache l1_cache_inst
    (
        .sys_clk        (sys_clk),
        .RST            (RST),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_rw         (cpu_rw),
        .cpu_wdata      (cpu_wdata),
        .cpu_ready      (cpu_ready),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_rw     (mem_req_rw),
        .mem_req_data   (mem_req_data),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_data  (mem_resp_data)
    );

    ////////////////////////////////////////////////////////////
    // bookkeeping shared by the processes
    int errors = 0;
    int replies = 0;
    logic timed_out = 1'b0;
    logic busy = 1'b0;                           // one cpu request in flight
    logic [31:0] lfsr_q = 32'h85d6963e;
    cache_pkg::addr_t cur_addr;
    logic             cur_rw;
    cache_pkg::word_t cur_wdata;
    logic             exp_wb;                    // dirty victim expected this request
    cache_pkg::addr_t exp_wb_addr;
    cache_pkg::addr_t exp_rd_addr;
    int wr_seen;
    int rd_seen;

    cache_pkg::word_t shadow [cache_pkg::addr_t];     // latest value of every written word
    cache_pkg::line_t mem_lines [cache_pkg::addr_t];  // lines written back to memory

    // set model, follows the cache's own victim rule
    cache_pkg::tag_t m_tag0 [cache_pkg::NUM_SETS];
    cache_pkg::tag_t m_tag1 [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_SETS-1:0] m_val0;
    logic [cache_pkg::NUM_SETS-1:0] m_val1;
    logic [cache_pkg::NUM_SETS-1:0] m_dty0;
    logic [cache_pkg::NUM_SETS-1:0] m_dty1;
    logic [cache_pkg::NUM_SETS-1:0] m_lru;

    initial
    begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic cache_pkg::addr_t line_of(input cache_pkg::addr_t a);
        return {a[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};
    endfunction

    // untouched memory word, depends on every address bit
    function automatic cache_pkg::word_t pattern_word(input cache_pkg::addr_t a);
        return cache_pkg::word_t'(a) ^ FILL_PATTERN;
    endfunction

    // expected word for a cpu access
    function automatic cache_pkg::word_t ref_word(input cache_pkg::addr_t a);
        if (shadow.exists(a))
            return shadow[a];
        return pattern_word(a);
    endfunction

    function automatic cache_pkg::line_t shadow_line(input cache_pkg::addr_t la);
        cache_pkg::line_t l;
        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++)
            l[k*cache_pkg::WORD_W +: cache_pkg::WORD_W] = ref_word(la + cache_pkg::addr_t'(k));
        return l;
    endfunction

    function automatic cache_pkg::line_t mem_line(input cache_pkg::addr_t la);
        cache_pkg::line_t l;
        if (mem_lines.exists(la))
            return mem_lines[la];
        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++)
            l[k*cache_pkg::WORD_W +: cache_pkg::WORD_W] = pattern_word(la + cache_pkg::addr_t'(k));
        return l;
    endfunction

    // four tags over two sets, so sets fill and conflict
    function automatic cache_pkg::addr_t pool_addr(input logic [4:0] sel);
        cache_pkg::tag_t   t;
        cache_pkg::index_t ix;
        case (sel[4:3])
            2'd0:    t = 13'h0001;
            2'd1:    t = 13'h1a2b;
            2'd2:    t = 13'h0f0f;
            default: t = 13'h1555;
        endcase
        ix = sel[2] ? 12'hfa5 : 12'h03c;
        return {t, ix, sel[1:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic compare_word(input string name, input cache_pkg::word_t got,
                                input cache_pkg::word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input cache_pkg::addr_t got,
                                input cache_pkg::addr_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_line(input string name, input cache_pkg::line_t got,
                                input cache_pkg::line_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // predicts hit and dirty eviction, then updates the set as the cache will
    task automatic model_access(input cache_pkg::addr_t a, input logic rw, output logic hit,
                                output logic wb, output cache_pkg::addr_t wb_addr);
        cache_pkg::tag_t   t;
        cache_pkg::index_t ix;
        logic              way;
        t  = a[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
        ix = a[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
        hit = 1'b0;
        wb = 1'b0;
        wb_addr = '0;
        if (m_val0[ix] && m_tag0[ix] == t)
        begin
            hit = 1'b1;
            way = 1'b0;
        end
        else if (m_val1[ix] && m_tag1[ix] == t)
        begin
            hit = 1'b1;
            way = 1'b1;
        end
        else
        begin
            way = !m_val0[ix] ? 1'b0 : (!m_val1[ix] ? 1'b1 : m_lru[ix]);
            if (way)
            begin
                wb = m_val1[ix] && m_dty1[ix];
                wb_addr = {m_tag1[ix], ix, {cache_pkg::OFFSET_W{1'b0}}};
                m_tag1[ix] = t;
                m_val1[ix] = 1'b1;
                m_dty1[ix] = 1'b0;               // fill is clean
            end
            else
            begin
                wb = m_val0[ix] && m_dty0[ix];
                wb_addr = {m_tag0[ix], ix, {cache_pkg::OFFSET_W{1'b0}}};
                m_tag0[ix] = t;
                m_val0[ix] = 1'b1;
                m_dty0[ix] = 1'b0;
            end
        end
        m_lru[ix] = ~way;                        // re-compare after a fill is a hit too
        if (rw && way)
            m_dty1[ix] = 1'b1;
        if (rw && !way)
            m_dty0[ix] = 1'b1;
    endtask

    // one cpu request, waits for cpu_ready with a timeout
    task automatic do_access(input cache_pkg::addr_t a, input logic rw,
                             input cache_pkg::word_t data);
        logic             hit;
        logic             wb;
        cache_pkg::addr_t wb_addr;
        int               cycles;
        if (!timed_out)
        begin
            model_access(a, rw, hit, wb, wb_addr);
            @(posedge sys_clk);
            cur_addr = a;
            cur_rw = rw;
            cur_wdata = data;
            exp_wb = wb;
            exp_wb_addr = wb_addr;
            exp_rd_addr = line_of(a);
            wr_seen = 0;
            rd_seen = 0;
            busy = 1'b1;
            cpu_valid <= 1'b1;
            cpu_addr  <= a;
            cpu_rw    <= rw;
            cpu_wdata <= data;
            @(posedge sys_clk);
            cpu_valid <= 1'b0;                   // single cycle strobe
            cycles = 0;
            do
            begin
                @(negedge sys_clk);
                cycles++;
            end
            while (!cpu_ready && cycles < READY_LIMIT);
            if (!cpu_ready)
            begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: no cpu_ready within %0d cycles for address %h", cycles, a);
            end
            else
            begin
                if (hit && cycles != 1)
                begin
                    errors++;
                    $display("hit on address %h took %0d cycles instead of one", a, cycles);
                end
                if (wr_seen != int'(wb))
                begin
                    errors++;
                    $display("address %h: %0d write-backs seen, %0d expected", a, wr_seen, wb);
                end
                if (rd_seen != (hit ? 0 : 1))
                begin
                    errors++;
                    $display("address %h: %0d line reads seen, hit expected %b", a, rd_seen, hit);
                end
            end
            @(posedge sys_clk);
            busy = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare process, every reply against the reference word
    always @(negedge sys_clk)
    begin
        if (cpu_ready && !busy)
        begin
            errors++;
            $display("cpu_ready raised at time %0t with no request in flight", $time);
        end
        else if (cpu_ready)
        begin
            compare_word("cpu_rdata", cpu_rdata, ref_word(cur_addr));
            replies++;
            if (cur_rw)
                shadow[cur_addr] = cur_wdata;    // old value returned, now update
        end
    end

    // memory model, write-back absorbed at once, read answered after 1 to 8 cycles
    initial
    begin
        logic [31:0]      r;
        int               lat;
        cache_pkg::line_t resp;
        mem_resp_ready <= 1'b0;
        mem_resp_data  <= '0;
        forever
        begin
            @(negedge sys_clk);
            if (mem_req_valid && !busy)
            begin
                errors++;
                $display("memory request at time %0t with no cpu request in flight", $time);
            end
            else if (mem_req_valid && mem_req_rw)
            begin
                wr_seen++;
                if (!exp_wb)
                begin
                    errors++;
                    $display("write-back at time %0t for a clean or empty victim", $time);
                end
                else
                begin
                    compare_addr("mem_req_addr", mem_req_addr, exp_wb_addr);
                    compare_line("mem_req_data", mem_req_data, shadow_line(exp_wb_addr));
                end
                mem_lines[mem_req_addr] = mem_req_data;
            end
            else if (mem_req_valid)
            begin
                rd_seen++;
                compare_addr("mem_req_addr", mem_req_addr, exp_rd_addr);
                if (exp_wb && wr_seen == 0)
                begin
                    errors++;
                    $display("line read at time %0t came before the write-back", $time);
                end
                r = rand_bits(3);
                lat = 1 + int'(r[2:0]);
                resp = mem_line(line_of(mem_req_addr));
                repeat (lat) @(posedge sys_clk);
                mem_resp_ready <= 1'b1;
                mem_resp_data  <= resp;
                @(posedge sys_clk);
                mem_resp_ready <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    initial
    begin
        logic [31:0] r;
        logic        rw;
        m_val0 = '0;
        m_val1 = '0;
        m_dty0 = '0;
        m_dty1 = '0;
        m_lru  = '0;
        RST       <= 1'b1;
        cpu_valid <= 1'b0;
        cpu_addr  <= '0;
        cpu_rw    <= 1'b0;
        cpu_wdata <= '0;
        repeat (16) @(posedge sys_clk);          // monitors flag any strobe in reset
        RST <= 1'b0;
        repeat (3) @(posedge sys_clk);

        do_access(pool_addr(5'b00000), 1'b0, '0);            // cold read miss
        do_access(pool_addr(5'b00000), 1'b0, '0);            // now resident
        do_access(pool_addr(5'b00001), 1'b1, 32'hdead_beef); // write hit, line dirty
        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++)
            do_access(pool_addr({3'b000, 2'(k)}), 1'b0, '0);
        do_access(pool_addr(5'b01001), 1'b0, '0);            // second way of the set
        do_access(pool_addr(5'b10010), 1'b0, '0);            // evicts dirty first tag
        do_access(pool_addr(5'b00011), 1'b0, '0);            // evicts clean line

        for (int i = 0; i < RANDOM_OPS && !timed_out; i++)
        begin
            r = rand_bits(1);
            rw = r[0];
            r = rand_bits(5);
            do_access(pool_addr(r[4:0]), rw, rand_bits(32));
        end

        $display("errors: %0d, cpu replies checked: %0d", errors, replies);
        if (errors == 0 && replies > 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: l1_cache/l1_cache.sv
// l1_cache: two-way write-back L1 data cache, controller joined to tag and line stores
`timescale 1ns/1ps

module l1_cache
(
    input  logic               sys_clk,
    input  logic               RST,
    input  logic               cpu_valid,
    input  cache_pkg::addr_t   cpu_addr,
    input  logic               cpu_rw,
    input  cache_pkg::word_t   cpu_wdata,
    output logic               cpu_ready,
    output cache_pkg::word_t   cpu_rdata,
    output logic               mem_req_valid,
    output cache_pkg::addr_t   mem_req_addr,
    output logic               mem_req_rw,
    output cache_pkg::line_t   mem_req_data,
    input  logic               mem_resp_ready,
    input  cache_pkg::line_t   mem_resp_data
);

    // shared array controls
    cache_pkg::index_t  index;
    logic               write_en;
    logic               write_way;

    // tag store
    cache_pkg::tag_t    write_tag;
    logic               write_dirty;
    logic               touch_en;
    logic               touch_way;
    cache_pkg::tag_t    rd_tag0;
    cache_pkg::tag_t    rd_tag1;
    logic               rd_valid0;
    logic               rd_valid1;
    logic               rd_dirty0;
    logic               rd_dirty1;
    logic               rd_lru;

    // line store
    logic               fill;
    cache_pkg::offset_t word_sel;
    cache_pkg::word_t   wdata;
    cache_pkg::line_t   fill_data;
    cache_pkg::line_t   rd_line0;
    cache_pkg::line_t   rd_line1;

    ////////////////////////////////////////////////////////////
    cache_ctrl cache_ctrl_inst
    (
        .sys_clk        (sys_clk),
        .RST            (RST),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_rw         (cpu_rw),
        .cpu_wdata      (cpu_wdata),
        .cpu_ready      (cpu_ready),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_rw     (mem_req_rw),
        .mem_req_data   (mem_req_data),
        .mem_resp_ready (mem_resp_ready),
        .mem_resp_data  (mem_resp_data),
        .index          (index),
        .write_en       (write_en),
        .write_way      (write_way),
        .write_tag      (write_tag),
        .write_dirty    (write_dirty),
        .touch_en       (touch_en),
        .touch_way      (touch_way),
        .rd_tag0        (rd_tag0),
        .rd_tag1        (rd_tag1),
        .rd_valid0      (rd_valid0),
        .rd_valid1      (rd_valid1),
        .rd_dirty0      (rd_dirty0),
        .rd_dirty1      (rd_dirty1),
        .rd_lru         (rd_lru),
        .fill           (fill),
        .word_sel       (word_sel),
        .wdata          (wdata),
        .fill_data      (fill_data),
        .rd_line0       (rd_line0),
        .rd_line1       (rd_line1)
    );

    tag_store tag_store_inst
    (
        .sys_clk     (sys_clk),
        .RST         (RST),
        .index       (index),
        .write_en    (write_en),
        .write_way   (write_way),
        .write_tag   (write_tag),
        .write_dirty (write_dirty),
        .touch_en    (touch_en),
        .touch_way   (touch_way),
        .rd_tag0     (rd_tag0),
        .rd_tag1     (rd_tag1),
        .rd_valid0   (rd_valid0),
        .rd_valid1   (rd_valid1),
        .rd_dirty0   (rd_dirty0),
        .rd_dirty1   (rd_dirty1),
        .rd_lru      (rd_lru)
    );

    // same index and write strobe as the tag store
    line_store line_store_inst
    (
        .sys_clk   (sys_clk),
        .index     (index),
        .write_en  (write_en),
        .write_way (write_way),
        .fill      (fill),
        .word_sel  (word_sel),
        .wdata     (wdata),
        .fill_data (fill_data),
        .rd_line0  (rd_line0),
        .rd_line1  (rd_line1)
    );

endmodule

// File: l1_cache/cache_ctrl.sv
// cache_ctrl FSM detects hits, picks victims, runs write-back and fill and answers the cpu
`timescale 1ns/1ps

module cache_ctrl
(
    input  logic                sys_clk,
    input  logic                RST,
    // cpu side
    input  logic                cpu_valid,
    input  cache_pkg::addr_t    cpu_addr,
    input  logic                cpu_rw,        // 1 = write
    input  cache_pkg::word_t    cpu_wdata,
    output logic                cpu_ready,
    output cache_pkg::word_t    cpu_rdata,
    // memory side
    output logic                mem_req_valid,
    output cache_pkg::addr_t    mem_req_addr,
    output logic                mem_req_rw,
    output cache_pkg::line_t    mem_req_data,
    input  logic                mem_resp_ready,
    input  cache_pkg::line_t    mem_resp_data,
    // controls shared by both stores
    output cache_pkg::index_t   index,
    output logic                write_en,
    output logic                write_way,
    // tag store
    output cache_pkg::tag_t     write_tag,
    output logic                write_dirty,
    output logic                touch_en,
    output logic                touch_way,
    input  cache_pkg::tag_t     rd_tag0,
    input  cache_pkg::tag_t     rd_tag1,
    input  logic                rd_valid0,
    input  logic                rd_valid1,
    input  logic                rd_dirty0,
    input  logic                rd_dirty1,
    input  logic                rd_lru,
    // line store
    output logic                fill,
    output cache_pkg::offset_t  word_sel,
    output cache_pkg::word_t    wdata,
    output cache_pkg::line_t    fill_data,
    input  cache_pkg::line_t    rd_line0,
    input  cache_pkg::line_t    rd_line1
);

    typedef enum logic [2:0]
    {
        idle,
        compare_tag,
        write_back,
        allocate,
        allocate_wait
    } cache_state_t;

    cache_state_t state;
    cache_state_t state_nxt;

    // request held for the whole transaction
    cache_pkg::addr_t  req_addr;
    logic              req_rw;
    cache_pkg::word_t  req_wdata;
    logic              victim_q;    // way chosen at the miss and filled in allocate

    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              hit_way;
    logic              victim;
    logic              victim_dirty;
    cache_pkg::tag_t   victim_tag;
    cache_pkg::line_t  hit_line;
    cache_pkg::line_t  victim_line;

    assign req_offset = req_addr[cache_pkg::OFFSET_W-1:0];
    assign req_index  = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign req_tag    = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

    // arrays look up the new set while idle and the held one otherwise
    assign index = (state == idle) ? cpu_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]
                                   : req_index;

    ////////////////////////////////////////////////////////////
    // hit detection and victim selection
    assign hit0    = rd_valid0 && (rd_tag0 == req_tag);
    assign hit1    = rd_valid1 && (rd_tag1 == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;         // way 1 only when way 0 missed
    assign hit_line = hit_way ? rd_line1 : rd_line0;

    // empty way first and lru only in a full set
    assign victim       = !rd_valid0 ? 1'b0 : (!rd_valid1 ? 1'b1 : rd_lru);
    assign victim_dirty = victim ? (rd_valid1 && rd_dirty1) : (rd_valid0 && rd_dirty0);
    assign victim_tag   = victim ? rd_tag1 : rd_tag0;
    assign victim_line  = victim ? rd_line1 : rd_line0;

    // old word of the line and so the reply to a write
    assign cpu_rdata = hit_line[int'(req_offset) * cache_pkg::WORD_W +: cache_pkg::WORD_W];

    // line addresses with offset forced to zero
    assign mem_req_addr = mem_req_rw
        ? {victim_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}}   // write-back target
        : {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};     // line to fetch
    assign mem_req_data = victim_line;     // only meaningful with rw = 1

    assign write_tag = req_tag;            // same tag for write hit and fill
    assign word_sel  = req_offset;
    assign wdata     = req_wdata;
    assign fill_data = mem_resp_data;
    assign touch_way = hit_way;

    always_ff @(posedge sys_clk)
    begin
        if (RST)
            state <= idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge sys_clk)
    begin
        if (state == idle && cpu_valid)
        begin
            req_addr  <= cpu_addr;
            req_rw    <= cpu_rw;
            req_wdata <= cpu_wdata;
        end
        if (state == compare_tag && !hit)
            victim_q <= victim;    // stays put through write_back and allocate
    end

    ////////////////////////////////////////////////////////////
    // next state and strobes
    always_comb
    begin
        state_nxt     = state;
        cpu_ready     = 1'b0;
        mem_req_valid = 1'b0;
        mem_req_rw    = 1'b0;
        write_en      = 1'b0;
        write_way     = hit_way;
        write_dirty   = 1'b0;
        fill          = 1'b0;
        touch_en      = 1'b0;
        case (state)
            idle:
            begin
                if (cpu_valid)
                    state_nxt = compare_tag;
            end
            compare_tag:
            begin
                if (hit)
                begin
                    cpu_ready   = 1'b1;
                    touch_en    = 1'b1;
                    write_en    = req_rw;    // merge word and mark line dirty
                    write_dirty = 1'b1;
                    state_nxt   = idle;
                end
                else
                begin
                    mem_req_valid = 1'b1;
                    mem_req_rw    = victim_dirty;   // evict first if dirty
                    state_nxt     = victim_dirty ? write_back : allocate;
                end
            end
            write_back:
            begin
                mem_req_valid = 1'b1;    // victim gone so fetch now
                state_nxt     = allocate;
            end
            allocate:
            begin
                write_way = victim_q;
                if (mem_resp_ready)
                begin
                    write_en  = 1'b1;    // new tag with dirty clear
                    fill      = 1'b1;
                    state_nxt = allocate_wait;
                end
            end
            allocate_wait:
                state_nxt = compare_tag;   // re-read arrays and hit next
            default:
                state_nxt = idle;
        endcase
    end

    // no back-pressure so the cpu waits for cpu_ready
    assert property (@(posedge sys_clk) disable iff (RST)
        cpu_valid |-> (state == idle))
        else $error("cache_ctrl: cpu_valid while a request is in flight");

    // memory answers only while a fill is awaited
    assert property (@(posedge sys_clk) disable iff (RST)
        mem_resp_ready |-> (state == allocate))
        else $error("cache_ctrl: mem_resp_ready with no line read outstanding");

endmodule

// File: logic/line_store.sv
// line_store: two-way line data array, word merge on write hit, whole-line fill on allocate
`timescale 1ns/1ps

module line_store
(
    input  logic                sys_clk,
    input  cache_pkg::index_t   index,       // set to read
    input  logic                write_en,
    input  logic                write_way,
    input  logic                fill,        // 1 = whole line from memory
    input  cache_pkg::offset_t  word_sel,
    input  cache_pkg::word_t    wdata,
    input  cache_pkg::line_t    fill_data,
    output cache_pkg::line_t    rd_line0,
    output cache_pkg::line_t    rd_line1
);

    cache_pkg::line_t line_mem0 [cache_pkg::NUM_SETS];
    cache_pkg::line_t line_mem1 [cache_pkg::NUM_SETS];

    cache_pkg::index_t idx_q;
    cache_pkg::line_t  merged;    // current line with one word swapped
    cache_pkg::line_t  wr_line;

    always_ff @(posedge sys_clk)
    begin
        idx_q <= index;
    end

    assign rd_line0 = line_mem0[idx_q];
    assign rd_line1 = line_mem1[idx_q];

    ////////////////////////////////////////////////////////////
    // read-modify-write of a single word
    always_comb
    begin
        merged = write_way ? rd_line1 : rd_line0;
        merged[int'(word_sel) * cache_pkg::WORD_W +: cache_pkg::WORD_W] = wdata;
    end

    assign wr_line = fill ? fill_data : merged;

    always_ff @(posedge sys_clk)
    begin
        if (write_en && !write_way)
            line_mem0[idx_q] <= wr_line;
        if (write_en && write_way)
            line_mem1[idx_q] <= wr_line;
    end

endmodule

// File: logic/tag_store.sv
// tag_store: per-way tag, valid and dirty arrays with one lru bit per set, registered index
`timescale 1ns/1ps

module tag_store
(
    input  logic               sys_clk,
    input  logic               RST,
    input  cache_pkg::index_t  index,        // set to read, sampled every edge
    input  logic               write_en,
    input  logic               write_way,
    input  cache_pkg::tag_t    write_tag,
    input  logic               write_dirty,
    input  logic               touch_en,     // hit seen, update lru
    input  logic               touch_way,
    output cache_pkg::tag_t    rd_tag0,
    output cache_pkg::tag_t    rd_tag1,
    output logic               rd_valid0,
    output logic               rd_valid1,
    output logic               rd_dirty0,
    output logic               rd_dirty1,
    output logic               rd_lru        // next victim way
);

    cache_pkg::tag_t tag_mem0 [cache_pkg::NUM_SETS];
    cache_pkg::tag_t tag_mem1 [cache_pkg::NUM_SETS];

    // status bits, one per line
    logic [cache_pkg::NUM_SETS-1:0] valid0;
    logic [cache_pkg::NUM_SETS-1:0] valid1;
    logic [cache_pkg::NUM_SETS-1:0] dirty0;
    logic [cache_pkg::NUM_SETS-1:0] dirty1;
    logic [cache_pkg::NUM_SETS-1:0] lru;

    cache_pkg::index_t idx_q;   // read and write both use the held set

    always_ff @(posedge sys_clk)
    begin
        idx_q <= index;
    end

    // tag rams
    always_ff @(posedge sys_clk)
    begin
        if (write_en && !write_way)
            tag_mem0[idx_q] <= write_tag;
        if (write_en && write_way)
            tag_mem1[idx_q] <= write_tag;
    end

    always_ff @(posedge sys_clk)
    begin
        if (RST)
        begin
            valid0 <= '0;   // whole cache invalid
            valid1 <= '0;
            dirty0 <= '0;
            dirty1 <= '0;
            lru    <= '0;   // way 0 first
        end
        else
        begin
            if (write_en)
            begin
                if (write_way)
                begin
                    valid1[idx_q] <= 1'b1;
                    dirty1[idx_q] <= write_dirty;
                end
                else
                begin
                    valid0[idx_q] <= 1'b1;
                    dirty0[idx_q] <= write_dirty;
                end
            end
            if (touch_en)
                lru[idx_q] <= ~touch_way;   // point at the other way
        end
    end

    assign rd_tag0   = tag_mem0[idx_q];
    assign rd_tag1   = tag_mem1[idx_q];
    assign rd_valid0 = valid0[idx_q];
    assign rd_valid1 = valid1[idx_q];
    assign rd_dirty0 = dirty0[idx_q];
    assign rd_dirty1 = dirty1[idx_q];
    assign rd_lru    = lru[idx_q];

    // a write hit rewrites and touches the line it hit, never its neighbour
    assert property (@(posedge sys_clk) disable iff (RST)
        (write_en && touch_en) |-> (write_way == touch_way))
        else $error("tag_store: write and lru touch name different ways");

endmodule

// File: common/cache_pkg.sv
// cache_pkg: address split, data widths and vector types shared by the L1 data cache
package cache_pkg;

    ////////////////////////////////////////////////////////////
    // address split  tag | index | offset
    localparam int ADDR_W   = 27;                           // cpu word address
    localparam int OFFSET_W = 2;                            // word within line
    localparam int INDEX_W  = 12;                           // set select
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 13 bits left for tag

    ////////////////////////////////////////////////////////////
    // data and array geometry
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;  // 128 bit line
    localparam int NUM_SETS       = 1 << INDEX_W;             // 4096 sets per way

    typedef logic [ADDR_W-1:0]   addr_t;    // word address
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;    // word k at bits k*32 +: 32

endpackage
